// File: all.f
+incdir+test
design/backend_pkg.sv
design/mem_wb_if.sv
design/mem_stage.sv
design/wb_unit.sv
design/commit_tracer.sv
design/reg_file.sv
design/rv64_backend.sv
test/tb_backend.sv

// File: design/backend_pkg.sv
package backend_pkg;

	localparam int XLEN     = 64;
	localparam int OT_WIDTH = 15;

	// One-hot opcode class positions, 12 to 14 are spare
	localparam int OT_LUI     = 0;
	localparam int OT_AUIPC   = 1;
	localparam int OT_JAL     = 2;
	localparam int OT_JALR    = 3;
	localparam int OT_BRANCH  = 4;
	localparam int OT_LOAD    = 5;
	localparam int OT_STORE   = 6;
	localparam int OT_OPIMM   = 7;
	localparam int OT_OP      = 8;
	localparam int OT_OPIMM32 = 9;
	localparam int OT_OP32    = 10;
	localparam int OT_SYSTEM  = 11;

	// Classes that produce a value for rd
	localparam logic [OT_WIDTH-1:0] WRITES_RD_MASK = OT_WIDTH'(
		(1 << OT_LUI) | (1 << OT_AUIPC) | (1 << OT_JAL) | (1 << OT_JALR) |
		(1 << OT_LOAD) | (1 << OT_OPIMM) | (1 << OT_OP) | (1 << OT_OPIMM32) |
		(1 << OT_OP32));

	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_kind_e;
	typedef enum logic [1:0] {FLOW_NONE, FLOW_CALL, FLOW_RET} flow_kind_e;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo5;
		logic [6:0] opcode;
	} s_fmt_t;

	// Same instruction bits seen as I-type or S-type
	typedef union packed {
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
	} inst_word_u;

endpackage

// File: design/commit_tracer.sv
module commit_tracer (
	input  logic                                retire,
	input  logic [backend_pkg::XLEN-1:0]        wb_pc,
	input  logic [31:0]                         wb_inst,
	input  logic [backend_pkg::OT_WIDTH-1:0]    wb_opcode_type,
	input  logic [backend_pkg::XLEN-1:0]        wb_mem_addr,
	output logic [backend_pkg::XLEN-1:0]        retire_pc,
	output logic [31:0]                         retire_inst,
	output backend_pkg::mem_kind_e              retire_mem_kind,
	output logic [backend_pkg::XLEN-1:0]        retire_mem_addr,
	output logic [backend_pkg::XLEN-1:0]        retire_mem_offset,
	output backend_pkg::flow_kind_e             retire_flow_kind
);

	backend_pkg::inst_word_u iw;
	logic [11:0]             s_imm;

	assign iw    = wb_inst;
	assign s_imm = {iw.s_fmt.imm_hi7, iw.s_fmt.imm_lo5};

	always_comb begin
		retire_pc         = '0;
		retire_inst       = '0;
		retire_mem_kind   = backend_pkg::MEM_NONE;
		retire_mem_addr   = '0;
		retire_mem_offset = '0;
		retire_flow_kind  = backend_pkg::FLOW_NONE;

		if (retire) begin
			retire_pc   = wb_pc;
			retire_inst = wb_inst;

			// Only legal RV64 widths count as an access
			if (wb_opcode_type[backend_pkg::OT_LOAD] && iw.i_fmt.funct3 <= 3'd6) begin
				retire_mem_kind   = backend_pkg::MEM_LOAD;
				retire_mem_addr   = wb_mem_addr;
				retire_mem_offset = {{(backend_pkg::XLEN-12){iw.i_fmt.imm12[11]}},
				                     iw.i_fmt.imm12};
			end else if (wb_opcode_type[backend_pkg::OT_STORE] &&
			             iw.s_fmt.funct3 <= 3'd3) begin
				retire_mem_kind   = backend_pkg::MEM_STORE;
				retire_mem_addr   = wb_mem_addr;
				retire_mem_offset = {{(backend_pkg::XLEN-12){s_imm[11]}}, s_imm};
			end

			if ((wb_opcode_type[backend_pkg::OT_JAL] || wb_opcode_type[backend_pkg::OT_JALR])
			    && iw.i_fmt.rd == 5'd1) begin
				retire_flow_kind = backend_pkg::FLOW_CALL;  // Link into ra
			end else if (wb_opcode_type[backend_pkg::OT_JALR] && iw.i_fmt.rd == 5'd0 &&
			             iw.i_fmt.rs1 == 5'd1 && iw.i_fmt.imm12 == 12'd0) begin
				retire_flow_kind = backend_pkg::FLOW_RET;   // Plain ret
			end
		end
	end

endmodule

// File: design/mem_stage.sv
module mem_stage #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                advance,
	input  logic                                ex_valid,
	input  logic [backend_pkg::XLEN-1:0]        ex_pc,
	input  logic [31:0]                         ex_inst,
	input  logic [backend_pkg::OT_WIDTH-1:0]    ex_opcode_type,
	input  logic [backend_pkg::XLEN-1:0]        ex_result,
	input  logic [backend_pkg::XLEN-1:0]        ex_store_data,
	mem_wb_if.src                               out
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic                                m_valid;
	logic [backend_pkg::XLEN-1:0]        m_pc;
	backend_pkg::inst_word_u             m_inst;
	logic [backend_pkg::OT_WIDTH-1:0]    m_opcode_type;
	logic [backend_pkg::XLEN-1:0]        m_result;     // Effective address for loads/stores
	logic [backend_pkg::XLEN-1:0]        m_store_data;

	logic [63:0] dmem [DMEM_WORDS];

	logic          is_load;
	logic          is_store;
	logic [2:0]    funct3;
	logic [AW-1:0] word_idx;
	logic [2:0]    byte_off;
	logic [63:0]   rd_word;
	logic [63:0]   rd_shifted;
	logic [63:0]   load_val;
	logic [7:0]    st_be;
	logic [63:0]   st_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			m_valid       <= 1'b0;
			m_opcode_type <= '0;
		end else if (advance) begin
			m_valid       <= ex_valid;
			m_pc          <= ex_pc;
			m_inst        <= ex_inst;
			m_opcode_type <= ex_opcode_type;
			m_result      <= ex_result;
			m_store_data  <= ex_store_data;
		end
	end

	assign is_load  = m_opcode_type[backend_pkg::OT_LOAD];
	assign is_store = m_opcode_type[backend_pkg::OT_STORE];
	assign funct3   = m_inst.i_fmt.funct3;
	assign word_idx = m_result[AW+2:3];
	assign byte_off = m_result[2:0];

	assign rd_word    = dmem[word_idx];                    // Async read
	assign rd_shifted = rd_word >> {byte_off, 3'b000};

	always_comb begin
		case (funct3)
			3'd0:    load_val = {{56{rd_shifted[7]}}, rd_shifted[7:0]};    // lb
			3'd1:    load_val = {{48{rd_shifted[15]}}, rd_shifted[15:0]};  // lh
			3'd2:    load_val = {{32{rd_shifted[31]}}, rd_shifted[31:0]};  // lw
			3'd4:    load_val = {56'b0, rd_shifted[7:0]};                  // lbu
			3'd5:    load_val = {48'b0, rd_shifted[15:0]};                 // lhu
			3'd6:    load_val = {32'b0, rd_shifted[31:0]};                 // lwu
			default: load_val = rd_word;                                   // ld
		endcase
	end

	// Byte enables for sb/sh/sw/sd, moved to the addressed lane
	always_comb begin
		case (funct3[1:0])
			2'd0:    st_be = 8'h01;
			2'd1:    st_be = 8'h03;
			2'd2:    st_be = 8'h0f;
			default: st_be = 8'hff;
		endcase
		st_be   = st_be << byte_off;
		st_data = m_store_data << {byte_off, 3'b000};
	end

	// Store commits as it leaves for WB
	always_ff @(posedge clk) begin
		if (advance && m_valid && is_store) begin
			for (int b = 0; b < 8; b++) begin
				if (st_be[b])
					dmem[word_idx][b*8 +: 8] <= st_data[b*8 +: 8];
			end
		end
	end

	assign out.valid       = m_valid;
	assign out.pc          = m_pc;
	assign out.inst        = m_inst;
	assign out.opcode_type = m_opcode_type;
	assign out.rd          = m_inst.i_fmt.rd;
	assign out.wen         = |(m_opcode_type & backend_pkg::WRITES_RD_MASK) &&
	                         (m_inst.i_fmt.rd != 5'd0);
	assign out.wdata       = is_load ? load_val : m_result;
	assign out.mem_addr    = (is_load || is_store) ? m_result : '0;

	// Decoder upstream must hand over exactly one class
	a_onehot_class: assert property (@(posedge clk) disable iff (rst)
		m_valid |-> $onehot(m_opcode_type));

	a_aligned: assert property (@(posedge clk) disable iff (rst)
		m_valid && (is_load || is_store) |->
			(byte_off & 3'((1 << funct3[1:0]) - 1)) == 3'd0);

endmodule

// File: design/mem_wb_if.sv
interface mem_wb_if;

	logic                                valid;
	logic [backend_pkg::XLEN-1:0]        pc;
	logic [31:0]                         inst;
	logic [backend_pkg::OT_WIDTH-1:0]    opcode_type;
	logic [4:0]                          rd;
	logic                                wen;      // Already masked for x0
	logic [backend_pkg::XLEN-1:0]        wdata;
	logic [backend_pkg::XLEN-1:0]        mem_addr; // Zero for non-memory ops

	modport src (
		output valid, pc, inst, opcode_type, rd, wen, wdata, mem_addr
	);

	modport dst (
		input valid, pc, inst, opcode_type, rd, wen, wdata, mem_addr
	);

endinterface

// File: design/reg_file.sv
module reg_file (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            wr_en,
	input  logic [4:0]                      wr_addr,
	input  logic [backend_pkg::XLEN-1:0]    wr_data,
	input  logic [4:0]                      rs1_addr,
	input  logic [4:0]                      rs2_addr,
	output logic [backend_pkg::XLEN-1:0]    rs1_data,
	output logic [backend_pkg::XLEN-1:0]    rs2_data
);

	logic [backend_pkg::XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads see the old value during a write cycle
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

	// Upstream masks every write to x0
	a_x0_zero: assert property (@(posedge clk) disable iff (rst)
		regs[0] == '0);

endmodule

// File: design/rv64_backend.sv
module rv64_backend #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                advance,
	input  logic                                ex_valid,
	input  logic [63:0]                         ex_pc,
	input  logic [31:0]                         ex_inst,
	input  logic [14:0]                         ex_opcode_type,
	input  logic [63:0]                         ex_result,
	input  logic [63:0]                         ex_store_data,
	input  logic [4:0]                          rs1_addr,
	input  logic [4:0]                          rs2_addr,
	output logic [63:0]                         rs1_data,
	output logic [63:0]                         rs2_data,
	output logic                                wbu_writing_gpr,
	output logic [4:0]                          wbu_rd,
	output logic                                retire,
	output logic [63:0]                         retire_pc,
	output logic [31:0]                         retire_inst,
	output backend_pkg::mem_kind_e              retire_mem_kind,
	output logic [63:0]                         retire_mem_addr,
	output logic [63:0]                         retire_mem_offset,
	output backend_pkg::flow_kind_e             retire_flow_kind
);

	logic                                wr_en;
	logic [4:0]                          wr_addr;
	logic [backend_pkg::XLEN-1:0]        wr_data;
	logic [backend_pkg::XLEN-1:0]        wb_pc;
	logic [31:0]                         wb_inst;
	logic [backend_pkg::OT_WIDTH-1:0]    wb_opcode_type;
	logic [backend_pkg::XLEN-1:0]        wb_mem_addr;

	mem_wb_if mw_if ();

	mem_stage #(
		.DMEM_WORDS (DMEM_WORDS)
	) mem_stage_i (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.ex_valid       (ex_valid),
		.ex_pc          (ex_pc),
		.ex_inst        (ex_inst),
		.ex_opcode_type (ex_opcode_type),
		.ex_result      (ex_result),
		.ex_store_data  (ex_store_data),
		.out            (mw_if.src)
	);

	wb_unit wb_unit_i (
		.clk             (clk),
		.rst             (rst),
		.advance         (advance),
		.in              (mw_if.dst),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.wbu_writing_gpr (wbu_writing_gpr),
		.wbu_rd          (wbu_rd),
		.retire          (retire),
		.wb_pc           (wb_pc),
		.wb_inst         (wb_inst),
		.wb_opcode_type  (wb_opcode_type),
		.wb_mem_addr     (wb_mem_addr)
	);

	commit_tracer commit_tracer_i (
		.retire            (retire),
		.wb_pc             (wb_pc),
		.wb_inst           (wb_inst),
		.wb_opcode_type    (wb_opcode_type),
		.wb_mem_addr       (wb_mem_addr),
		.retire_pc         (retire_pc),
		.retire_inst       (retire_inst),
		.retire_mem_kind   (retire_mem_kind),
		.retire_mem_addr   (retire_mem_addr),
		.retire_mem_offset (retire_mem_offset),
		.retire_flow_kind  (retire_flow_kind)
	);

	reg_file reg_file_i (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

endmodule

// File: design/wb_unit.sv
module wb_unit (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                advance,
	mem_wb_if.dst                               in,
	output logic                                wr_en,
	output logic [4:0]                          wr_addr,
	output logic [backend_pkg::XLEN-1:0]        wr_data,
	output logic                                wbu_writing_gpr,
	output logic [4:0]                          wbu_rd,
	output logic                                retire,
	output logic [backend_pkg::XLEN-1:0]        wb_pc,
	output logic [31:0]                         wb_inst,
	output logic [backend_pkg::OT_WIDTH-1:0]    wb_opcode_type,
	output logic [backend_pkg::XLEN-1:0]        wb_mem_addr
);

	logic                                wb_valid;
	logic                                wb_wen;
	logic [4:0]                          wb_rd;
	logic [backend_pkg::XLEN-1:0]        wb_wdata;
	logic [backend_pkg::XLEN-1:0]        wb_pc_q;
	logic [31:0]                         wb_inst_q;
	logic [backend_pkg::OT_WIDTH-1:0]    wb_opcode_type_q;
	logic [backend_pkg::XLEN-1:0]        wb_mem_addr_q;

	// WB pipeline register, frozen while advance is low
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid         <= 1'b0;
			wb_wen           <= 1'b0;
			wb_rd            <= 5'd0;
			wb_opcode_type_q <= '0;
		end else if (advance) begin
			wb_valid         <= in.valid;
			wb_wen           <= in.wen;
			wb_rd            <= in.rd;
			wb_opcode_type_q <= in.opcode_type;
			wb_pc_q          <= in.pc;
			wb_inst_q        <= in.inst;
			wb_wdata         <= in.wdata;
			wb_mem_addr_q    <= in.mem_addr;
		end
	end

	assign retire  = wb_valid && advance;  // Leaves the pipe at this edge
	assign wr_en   = retire && wb_wen;
	assign wr_addr = wb_rd;
	assign wr_data = wb_wdata;

	// Pending write seen by forwarding even during a stall
	assign wbu_writing_gpr = wb_valid && wb_wen;
	assign wbu_rd          = wb_rd;

	assign wb_pc          = wb_pc_q;
	assign wb_inst        = wb_inst_q;
	assign wb_opcode_type = wb_opcode_type_q;
	assign wb_mem_addr    = wb_mem_addr_q;

	// wen was masked for x0 back in the memory stage
	a_wr_needs_valid: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> wr_addr != 5'd0);

endmodule

// File: run.sh
#!/bin/sh
# Build the backend testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_backend -f all.f -o sim_backend

# The log decides the result, so a crashing run still gets reported
./obj_dir/sim_backend > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: test/tb_vectors.svh
// Columns: pc, inst, one-hot class, ex_result, ex_store_data,
// then expected mem kind, mem offset, flow kind, writes rd, final rd value
typedef struct packed {
	logic [63:0]             pc;
	logic [31:0]             inst;
	logic [14:0]             opcode_type;
	logic [63:0]             result;
	logic [63:0]             store_data;
	backend_pkg::mem_kind_e  mem_kind;
	logic [63:0]             mem_offset;
	backend_pkg::flow_kind_e flow_kind;
	logic                    writes_rd;
	logic [63:0]             rd_value;
} vec_t;

localparam int N_VEC = 17;

// The four stores leave 0xfedcba98_80019cef in the word at 0x100
localparam vec_t VECTORS [N_VEC] = '{
	'{64'h1000, 32'h01453023, 15'h0040, 64'h100, 64'h0123_4567_89ab_cdef,  // sd x20, 0(x10)
	  backend_pkg::MEM_STORE, 64'h0, backend_pkg::FLOW_NONE, 1'b0, 64'h0},
	'{64'h1004, 32'h01552223, 15'h0040, 64'h104, 64'h1111_1111_fedc_ba98,  // sw x21, 4(x10)
	  backend_pkg::MEM_STORE, 64'h4, backend_pkg::FLOW_NONE, 1'b0, 64'h0},
	'{64'h1008, 32'h01651123, 15'h0040, 64'h102, 64'h2222_2222_2222_8001,  // sh x22, 2(x10)
	  backend_pkg::MEM_STORE, 64'h2, backend_pkg::FLOW_NONE, 1'b0, 64'h0},
	'{64'h100c, 32'hff758ca3, 15'h0040, 64'h101, 64'h3333_3333_3333_339c,  // sb x23, -7(x11)
	  backend_pkg::MEM_STORE, 64'hffff_ffff_ffff_fff9, backend_pkg::FLOW_NONE, 1'b0, 64'h0},
	'{64'h1010, 32'h00053583, 15'h0020, 64'h100, 64'h0,  // ld x11, 0(x10)
	  backend_pkg::MEM_LOAD, 64'h0, backend_pkg::FLOW_NONE, 1'b1, 64'hfedc_ba98_8001_9cef},
	'{64'h1014, 32'h00452603, 15'h0020, 64'h104, 64'h0,  // lw x12, 4(x10)
	  backend_pkg::MEM_LOAD, 64'h4, backend_pkg::FLOW_NONE, 1'b1, 64'hffff_ffff_fedc_ba98},
	'{64'h1018, 32'h00456683, 15'h0020, 64'h104, 64'h0,  // lwu x13, 4(x10)
	  backend_pkg::MEM_LOAD, 64'h4, backend_pkg::FLOW_NONE, 1'b1, 64'h0000_0000_fedc_ba98},
	'{64'h101c, 32'h00251703, 15'h0020, 64'h102, 64'h0,  // lh x14, 2(x10)
	  backend_pkg::MEM_LOAD, 64'h2, backend_pkg::FLOW_NONE, 1'b1, 64'hffff_ffff_ffff_8001},
	'{64'h1020, 32'h00255783, 15'h0020, 64'h102, 64'h0,  // lhu x15, 2(x10)
	  backend_pkg::MEM_LOAD, 64'h2, backend_pkg::FLOW_NONE, 1'b1, 64'h8001},
	'{64'h1024, 32'h00150803, 15'h0020, 64'h101, 64'h0,  // lb x16, 1(x10)
	  backend_pkg::MEM_LOAD, 64'h1, backend_pkg::FLOW_NONE, 1'b1, 64'hffff_ffff_ffff_ff9c},
	'{64'h1028, 32'hff85c883, 15'h0020, 64'h100, 64'h0,  // lbu x17, -8(x11)
	  backend_pkg::MEM_LOAD, 64'hffff_ffff_ffff_fff8, backend_pkg::FLOW_NONE, 1'b1, 64'hef},
	'{64'h102c, 32'h040000ef, 15'h0004, 64'h1030, 64'h0,  // jal x1, +64
	  backend_pkg::MEM_NONE, 64'h0, backend_pkg::FLOW_CALL, 1'b1, 64'h1030},
	'{64'h106c, 32'h000280e7, 15'h0008, 64'h1070, 64'h0,  // jalr x1, 0(x5)
	  backend_pkg::MEM_NONE, 64'h0, backend_pkg::FLOW_CALL, 1'b1, 64'h1070},
	'{64'h2000, 32'h00008067, 15'h0008, 64'h2004, 64'h0,  // jalr x0, 0(x1)
	  backend_pkg::MEM_NONE, 64'h0, backend_pkg::FLOW_RET, 1'b0, 64'h0},
	'{64'h1070, 32'h008302e7, 15'h0008, 64'h1074, 64'h0,  // jalr x5, 8(x6)
	  backend_pkg::MEM_NONE, 64'h0, backend_pkg::FLOW_NONE, 1'b1, 64'h1074},
	'{64'h3000, 32'h00b50863, 15'h0010, 64'hdead, 64'h0,  // beq x10, x11, +16
	  backend_pkg::MEM_NONE, 64'h0, backend_pkg::FLOW_NONE, 1'b0, 64'h0},
	'{64'h3004, 32'h00d60033, 15'h0100, 64'h5555, 64'h0,  // add x0, x12, x13
	  backend_pkg::MEM_NONE, 64'h0, backend_pkg::FLOW_NONE, 1'b0, 64'h0}
};

// File: test/tb_backend.sv
module tb_backend;

	`include "tb_vectors.svh"

	localparam int MAX_CYCLES = 400;

	logic                    clk;
	logic                    rst;
	logic                    advance;
	logic                    ex_valid;
	logic [63:0]             ex_pc;
	logic [31:0]             ex_inst;
	logic [14:0]             ex_opcode_type;
	logic [63:0]             ex_result;
	logic [63:0]             ex_store_data;
	logic [4:0]              rs1_addr;
	logic [4:0]              rs2_addr;
	logic [63:0]             rs1_data;
	logic [63:0]             rs2_data;
	logic                    wbu_writing_gpr;
	logic [4:0]              wbu_rd;
	logic                    retire;
	logic [63:0]             retire_pc;
	logic [31:0]             retire_inst;
	backend_pkg::mem_kind_e  retire_mem_kind;
	logic [63:0]             retire_mem_addr;
	logic [63:0]             retire_mem_offset;
	backend_pkg::flow_kind_e retire_flow_kind;

	int          seed;
	int          issue_idx;   // Next table entry to offer
	int          retire_idx;  // Next table entry expected to retire
	int          cycles;
	int          checks;
	int          errors;
	logic [63:0] exp_regs [32];

	rv64_backend #(
		.DMEM_WORDS (256)
	) dut_i (
		.clk               (clk),
		.rst               (rst),
		.advance           (advance),
		.ex_valid          (ex_valid),
		.ex_pc             (ex_pc),
		.ex_inst           (ex_inst),
		.ex_opcode_type    (ex_opcode_type),
		.ex_result         (ex_result),
		.ex_store_data     (ex_store_data),
		.rs1_addr          (rs1_addr),
		.rs2_addr          (rs2_addr),
		.rs1_data          (rs1_data),
		.rs2_data          (rs2_data),
		.wbu_writing_gpr   (wbu_writing_gpr),
		.wbu_rd            (wbu_rd),
		.retire            (retire),
		.retire_pc         (retire_pc),
		.retire_inst       (retire_inst),
		.retire_mem_kind   (retire_mem_kind),
		.retire_mem_addr   (retire_mem_addr),
		.retire_mem_offset (retire_mem_offset),
		.retire_flow_kind  (retire_flow_kind)
	);

	always #10 clk = ~clk;

	task automatic expect_hex(input string name, input logic [63:0] got, input logic [63:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic apply_inputs();
		advance = ($random(seed) & 3) != 0;  // Roughly three cycles in four
		if (issue_idx < N_VEC) begin
			ex_valid       = 1'b1;
			ex_pc          = VECTORS[issue_idx].pc;
			ex_inst        = VECTORS[issue_idx].inst;
			ex_opcode_type = VECTORS[issue_idx].opcode_type;
			ex_result      = VECTORS[issue_idx].result;
			ex_store_data  = VECTORS[issue_idx].store_data;
		end else begin
			ex_valid       = 1'b0;  // Bubbles once the table is used up
			ex_opcode_type = '0;
		end
	endtask

	task automatic verify_retire(input int idx);
		vec_t        v;
		logic [63:0] want_addr;
		v = VECTORS[idx];
		want_addr = (v.mem_kind != backend_pkg::MEM_NONE) ? v.result : 64'h0;
		expect_hex("retire_pc", retire_pc, v.pc);
		expect_hex("retire_inst", 64'(retire_inst), 64'(v.inst));
		expect_hex("retire_mem_kind", 64'(retire_mem_kind), 64'(v.mem_kind));
		expect_hex("retire_mem_addr", retire_mem_addr, want_addr);
		expect_hex("retire_mem_offset", retire_mem_offset, v.mem_offset);
		expect_hex("retire_flow_kind", 64'(retire_flow_kind), 64'(v.flow_kind));
		expect_hex("wbu_writing_gpr", 64'(wbu_writing_gpr), 64'(v.writes_rd));
		if (v.writes_rd)
			expect_hex("wbu_rd", 64'(wbu_rd), 64'(v.inst[11:7]));
	endtask

	// Both read ports sweep the file from opposite ends
	task automatic compare_registers();
		for (int r = 0; r < 32; r++) begin
			@(posedge clk);
			#2;
			rs1_addr = 5'(r);
			rs2_addr = 5'(31 - r);
			@(negedge clk);
			expect_hex($sformatf("rs1_data[x%0d]", r), rs1_data, exp_regs[r]);
			expect_hex($sformatf("rs2_data[x%0d]", 31 - r), rs2_data, exp_regs[31 - r]);
		end
	endtask

	task automatic report_and_finish();
		$display("Run finished: %0d checks, %0d errors, %0d of %0d entries retired",
		         checks, errors, retire_idx, N_VEC);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	endtask

	// Retire monitor sampled mid-cycle
	always @(negedge clk) begin
		if (rst || !advance) begin
			expect_hex("retire", 64'(retire), 64'h0);
			expect_hex("retire_pc", retire_pc, 64'h0);  // Tracer shows zeros between retires
		end else if (retire) begin
			assert (retire_idx < N_VEC) else begin
				errors++;
				$display("A retire pulse came after every table entry had already retired");
			end
			if (retire_idx < N_VEC)
				verify_retire(retire_idx);
			retire_idx++;
		end
	end

	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		advance        = 1'b0;
		ex_valid       = 1'b0;
		ex_pc          = '0;
		ex_inst        = '0;
		ex_opcode_type = '0;
		ex_result      = '0;
		ex_store_data  = '0;
		rs1_addr       = '0;
		rs2_addr       = '0;
		seed           = 89;
		issue_idx      = 0;
		retire_idx     = 0;
		checks         = 0;
		errors         = 0;

		// Last writer of each rd wins
		for (int r = 0; r < 32; r++)
			exp_regs[r] = '0;
		for (int i = 0; i < N_VEC; i++) begin
			if (VECTORS[i].writes_rd)
				exp_regs[VECTORS[i].inst[11:7]] = VECTORS[i].rd_value;
		end

		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		apply_inputs();

		cycles = 0;
		while (retire_idx < N_VEC && cycles < MAX_CYCLES) begin
			@(posedge clk);
			if (advance && ex_valid)
				issue_idx++;  // Entry taken at this edge
			#2;
			apply_inputs();
			cycles++;
		end
		advance  = 1'b0;
		ex_valid = 1'b0;

		if (retire_idx < N_VEC) begin
			errors++;
			$display("Timed out after %0d cycles with only %0d of %0d entries retired",
			         cycles, retire_idx, N_VEC);
		end else begin
			// Bubbles through the drained pipe must not retire again
			advance = 1'b1;
			repeat (4) @(posedge clk);
			#2;
			advance = 1'b0;
			compare_registers();
		end
		report_and_finish();
	end

endmodule
